/* source/uart_rx_macros.svh */
// receiver constants for a 16x sample clock and 8 data bits with RX_HALF_BIT held at RX_OVERSAMPLE/2
`ifndef UART_RX_MACROS_SVH
`define UART_RX_MACROS_SVH

// sample clock ticks in one bit period
// tick counters are 4 bits so this cannot go above 16
`define RX_OVERSAMPLE 16

// ticks from the detected falling edge to the middle of the start bit
`define RX_HALF_BIT 8

// data bits in one frame, sent LSB first
// followed by one even parity bit and one stop bit
`define RX_DATA_BITS 8

`endif

/* source/uart_rx_pkg.sv */
// shared receiver types with 4-bit tick and bit counters sized for 16x oversampling and 8 data bits
`default_nettype none

`include "uart_rx_macros.svh"

package uart_rx_pkg;

  typedef logic [`RX_DATA_BITS-1:0] rx_byte_t; // one received data byte

  typedef logic [3:0] tick_count_t; // position within one bit period

  typedef logic [3:0] bit_index_t; // data bits collected so far, reaches 8

  // frame phases walked by the control FSM
  typedef enum logic [2:0]
  {
    idle,         // waiting for a falling edge on the line
    hunt_center,  // waiting for mid start bit to confirm it
    receive_data, // sampling the data bits
    check_parity, // sampling the parity bit
    check_stop    // sampling the stop bit
  } rx_state_t;

endpackage

`default_nettype wire

/* source/rx_line_frontend.sv */
// rxd is asynchronous and idles high, line_sync lags the pin by two clocks of the 16x sample clock
`timescale 1ns/100ps
`default_nettype none

module rx_line_frontend
(
  input  wire  Rx_sample_ENABLE, // 16x baud clock
  input  wire  reset,            // async, active high
  input  wire  rxd,              // raw serial line
  output logic line_sync,        // synchronized line level
  output logic fall_seen         // one clock pulse on a high to low edge
);

  logic sync_meta; // first synchronizer stage, may go metastable
  logic line_prev; // line_sync one clock earlier

  // two stage synchronizer plus an edge history stage
  always_ff @(posedge Rx_sample_ENABLE or posedge reset)
  begin
    if (reset)
    begin
      sync_meta <= 1'b1; // line idles high
      line_sync <= 1'b1;
      line_prev <= 1'b1;
    end
    else
    begin
      sync_meta <= rxd;
      line_sync <= sync_meta;
      line_prev <= line_sync;
    end
  end

  // high before, low now
  assign fall_seen = line_prev & ~line_sync;

endmodule

`default_nettype wire

/* source/rx_bit_timer.sv */
// tick spacing is fixed by RX_OVERSAMPLE, the first tick after a start lands RX_HALF_BIT clocks later
`timescale 1ns/100ps
`default_nettype none

`include "uart_rx_macros.svh"

module rx_bit_timer
  import uart_rx_pkg::*;
(
  input  wire  Rx_sample_ENABLE, // 16x baud clock
  input  wire  reset,            // async, active high
  input  wire  timer_start,      // pulse on a new start edge
  input  wire  timer_run,        // high while a frame is in progress
  output logic sample_tick       // one clock pulse at mid bit
);

  localparam tick_count_t TICK_LAST  = tick_count_t'(`RX_OVERSAMPLE - 1);
  localparam tick_count_t TICK_PRELD = tick_count_t'(`RX_OVERSAMPLE - `RX_HALF_BIT);

  tick_count_t tick_cnt; // position inside the current bit

  always_ff @(posedge Rx_sample_ENABLE or posedge reset)
  begin
    if (reset)
    begin
      tick_cnt <= '0;
    end
    else if (timer_start)
    begin
      tick_cnt <= TICK_PRELD; // only half a bit to run before the first tick
    end
    else if (timer_run)
    begin
      if (tick_cnt == TICK_LAST)
      begin
        tick_cnt <= '0; // wrap, one full bit to the next tick
      end
      else
      begin
        tick_cnt <= tick_cnt + 1'b1;
      end
    end
    else
    begin
      tick_cnt <= '0; // parked between frames
    end
  end

  // timer_run is low during the start pulse itself, so no tick leaks out there
  assign sample_tick = timer_run & (tick_cnt == TICK_LAST);

endmodule

`default_nettype wire

/* source/rx_data_shifter.sv */
// collects RX_DATA_BITS bits LSB first and ignores further shifts once byte_full is high
`timescale 1ns/100ps
`default_nettype none

`include "uart_rx_macros.svh"

module rx_data_shifter
  import uart_rx_pkg::*;
(
  input  wire      Rx_sample_ENABLE, // 16x baud clock
  input  wire      reset,            // async, active high
  input  wire      timer_start,      // new frame, clears the bit count
  input  wire      shift_en,         // mid bit sample of a data bit
  input  wire      line_sync,        // synchronized line level
  output rx_byte_t shift_data,       // bits gathered so far
  output logic     byte_full         // all data bits are in
);

  localparam bit_index_t BIT_LAST = bit_index_t'(`RX_DATA_BITS);

  bit_index_t bit_cnt; // data bits shifted in this frame

  always_ff @(posedge Rx_sample_ENABLE or posedge reset)
  begin
    if (reset)
    begin
      shift_data <= '0;
      bit_cnt    <= '0;
    end
    else if (timer_start)
    begin
      bit_cnt <= '0; // old byte stays until overwritten
    end
    else if (shift_en && !byte_full)
    begin
      shift_data <= {line_sync, shift_data[`RX_DATA_BITS-1:1]}; // enter at MSB, first bit ends in bit 0
      bit_cnt    <= bit_cnt + 1'b1;
    end
  end

  assign byte_full = (bit_cnt == BIT_LAST);

endmodule

`default_nettype wire

/* source/rx_frame_checker.sv */
// even parity only, one stop bit, and pulses land one clock after the stop bit sample
`timescale 1ns/100ps
`default_nettype none

module rx_frame_checker
  import uart_rx_pkg::*;
(
  input  wire      Rx_sample_ENABLE, // 16x baud clock
  input  wire      reset,            // async, active high
  input  wire      parity_strobe,    // mid bit sample of the parity bit
  input  wire      stop_strobe,      // mid bit sample of the stop bit
  input  wire      line_sync,        // synchronized line level
  input  wire rx_byte_t shift_data,  // collected data byte
  output rx_byte_t rx_data,          // last clean byte
  output logic     rx_valid,         // clean frame pulse
  output logic     rx_perror,        // parity error pulse
  output logic     rx_ferror         // framing error pulse
);

  logic parity_bad; // parity bit disagreed with the data

  // parity mismatch kept until the stop bit is seen
  always_ff @(posedge Rx_sample_ENABLE or posedge reset)
  begin
    if (reset)
    begin
      parity_bad <= 1'b0;
    end
    else if (parity_strobe)
    begin
      parity_bad <= line_sync ^ (^shift_data); // even parity over data plus parity bit
    end
  end

  // result pulses, each high for one clock only
  always_ff @(posedge Rx_sample_ENABLE or posedge reset)
  begin
    if (reset)
    begin
      rx_data   <= '0;
      rx_valid  <= 1'b0;
      rx_perror <= 1'b0;
      rx_ferror <= 1'b0;
    end
    else if (stop_strobe)
    begin
      rx_valid  <= ~parity_bad & line_sync;
      rx_perror <= parity_bad;
      rx_ferror <= ~line_sync; // stop bit must be high
      if (!parity_bad && line_sync)
      begin
        rx_data <= shift_data; // held until the next clean frame
      end
    end
    else
    begin
      rx_valid  <= 1'b0;
      rx_perror <= 1'b0;
      rx_ferror <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* source/rx_control.sv */
// rx_en is looked at only in idle, so a frame already started always runs to its stop bit
`timescale 1ns/100ps
`default_nettype none

module rx_control
  import uart_rx_pkg::*;
(
  input  wire  Rx_sample_ENABLE, // 16x baud clock
  input  wire  reset,            // async, active high
  input  wire  rx_en,            // receiver enable
  input  wire  fall_seen,        // falling edge on the line
  input  wire  line_sync,        // synchronized line level
  input  wire  sample_tick,      // mid bit tick from the bit timer
  input  wire  byte_full,        // all data bits collected
  output logic timer_start,      // restart the bit timer
  output logic timer_run,        // keep the bit timer going
  output logic shift_en,         // shift a data bit in
  output logic parity_strobe,    // sample the parity bit
  output logic stop_strobe       // sample the stop bit
);

  rx_state_t state;      // current frame phase
  rx_state_t state_next; // phase for the next clock

  always_ff @(posedge Rx_sample_ENABLE or posedge reset)
  begin
    if (reset)
    begin
      state <= idle;
    end
    else
    begin
      state <= state_next;
    end
  end

  always_comb
  begin
    state_next    = state;
    timer_start   = 1'b0;
    shift_en      = 1'b0;
    parity_strobe = 1'b0;
    stop_strobe   = 1'b0;
    case (state)
      idle:
      begin
        if (rx_en && fall_seen)
        begin
          timer_start = 1'b1; // first tick half a bit from now
          state_next  = hunt_center;
        end
      end
      hunt_center:
      begin
        if (sample_tick)
        begin
          // a line already back high was only a glitch
          state_next = line_sync ? idle : receive_data;
        end
      end
      receive_data:
      begin
        shift_en = sample_tick;
        if (byte_full)
        begin
          state_next = check_parity; // eighth bit is in, next tick is parity
        end
      end
      check_parity:
      begin
        parity_strobe = sample_tick;
        if (sample_tick)
        begin
          state_next = check_stop;
        end
      end
      check_stop:
      begin
        stop_strobe = sample_tick;
        if (sample_tick)
        begin
          state_next = idle; // ready for a start bit right after the stop sample
        end
      end
      default:
      begin
        state_next = idle;
      end
    endcase
  end

  assign timer_run = (state != idle);

endmodule

`default_nettype wire

/* source/uart_rx_top.sv */
// clocked by the 16x sample clock with no baud divider and no handshake, so unread bytes are overwritten
`timescale 1ns/100ps
`default_nettype none

module uart_rx_top
  import uart_rx_pkg::*;
(
  input  wire      Rx_sample_ENABLE, // 16x baud clock
  input  wire      reset,            // async, active high
  input  wire      rx_en,            // receiver enable
  input  wire      rxd,              // serial line, idles high
  output rx_byte_t rx_data,          // last clean byte
  output logic     rx_valid,         // clean frame pulse
  output logic     rx_perror,        // parity error pulse
  output logic     rx_ferror         // framing error pulse
);

  wire      line_sync;     // synchronized rxd
  wire      fall_seen;     // start edge candidate
  wire      timer_start;   // bit timer restart
  wire      timer_run;     // bit timer enable
  wire      sample_tick;   // mid bit tick
  wire      shift_en;      // data bit sample
  wire      parity_strobe; // parity bit sample
  wire      stop_strobe;   // stop bit sample
  wire      byte_full;     // data bits all in
  rx_byte_t shift_data;    // assembled byte

  rx_line_frontend rx_line_frontend_i
  (
    .Rx_sample_ENABLE (Rx_sample_ENABLE),
    .reset            (reset),
    .rxd              (rxd),
    .line_sync        (line_sync),
    .fall_seen        (fall_seen)
  );

  rx_control rx_control_i
  (
    .Rx_sample_ENABLE (Rx_sample_ENABLE),
    .reset            (reset),
    .rx_en            (rx_en),
    .fall_seen        (fall_seen),
    .line_sync        (line_sync),
    .sample_tick      (sample_tick),
    .byte_full        (byte_full),
    .timer_start      (timer_start),
    .timer_run        (timer_run),
    .shift_en         (shift_en),
    .parity_strobe    (parity_strobe),
    .stop_strobe      (stop_strobe)
  );

  rx_bit_timer rx_bit_timer_i
  (
    .Rx_sample_ENABLE (Rx_sample_ENABLE),
    .reset            (reset),
    .timer_start      (timer_start),
    .timer_run        (timer_run),
    .sample_tick      (sample_tick)
  );

  rx_data_shifter rx_data_shifter_i
  (
    .Rx_sample_ENABLE (Rx_sample_ENABLE),
    .reset            (reset),
    .timer_start      (timer_start),
    .shift_en         (shift_en),
    .line_sync        (line_sync),
    .shift_data       (shift_data),
    .byte_full        (byte_full)
  );

  rx_frame_checker rx_frame_checker_i
  (
    .Rx_sample_ENABLE (Rx_sample_ENABLE),
    .reset            (reset),
    .parity_strobe    (parity_strobe),
    .stop_strobe      (stop_strobe),
    .line_sync        (line_sync),
    .shift_data       (shift_data),
    .rx_data          (rx_data),
    .rx_valid         (rx_valid),
    .rx_perror        (rx_perror),
    .rx_ferror        (rx_ferror)
  );

endmodule

`default_nettype wire

/* verification/uart_rx_tb.sv */
// needs a sample clock at exactly 16x the bit rate, sends 200 random even parity frames from a fixed seed
`timescale 1ns/100ps
`default_nettype none

`include "uart_rx_macros.svh"

module uart_rx_tb
  import uart_rx_pkg::*;
();

  localparam int NUM_FRAMES     = 200;
  localparam int BIT_CYCLES     = `RX_OVERSAMPLE;
  localparam int FRAME_CYCLES   = 11 * BIT_CYCLES; // start, data, parity, stop
  localparam int GAP_MAX        = 40;              // longest idle gap between frames
  localparam int GLITCH_LOW     = 3;               // false start width
  localparam int GLITCH_SETTLE  = 20;              // high time after a false start
  localparam int LAT_MIN        = 150;             // start edge to result pulse
  localparam int LAT_MAX        = 180;
  localparam int TIMEOUT_CYCLES =
    NUM_FRAMES * (FRAME_CYCLES + GAP_MAX + GLITCH_LOW + GLITCH_SETTLE + 4) + 2000;

  logic     Rx_sample_ENABLE; // 16x baud clock
  logic     reset;
  logic     rx_en;
  logic     rxd;
  rx_byte_t rx_data;
  logic     rx_valid;
  logic     rx_perror;
  logic     rx_ferror;

  rx_byte_t exp_data_q[$];  // expected frames, oldest first
  logic     exp_perr_q[$];
  logic     exp_ferr_q[$];
  int       exp_start_q[$]; // cycle of each start edge

  int       cycle_count    = 0;
  int       error_count    = 0;
  int       frames_sent    = 0;
  int       results_seen   = 0;
  logic     monitor_on     = 1'b0;
  logic     pulse_now      = 1'b0;
  logic     pulse_prev     = 1'b0;
  rx_byte_t model_data     = '0; // last clean byte, what rx_data must hold
  logic [31:0] rng;

  uart_rx_top uart_rx_top_i
  (
    .Rx_sample_ENABLE (Rx_sample_ENABLE),
    .reset            (reset),
    .rx_en            (rx_en),
    .rxd              (rxd),
    .rx_data          (rx_data),
    .rx_valid         (rx_valid),
    .rx_perror        (rx_perror),
    .rx_ferror        (rx_ferror)
  );

  always #50 Rx_sample_ENABLE = ~Rx_sample_ENABLE; // 100 ns period

  always @(posedge Rx_sample_ENABLE)
  begin
    cycle_count++;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // every wait ends on a falling edge, where inputs change
  task automatic wait_cycles(input int count);
    for (int i = 0; i < count; i++)
    begin
      @(negedge Rx_sample_ENABLE);
    end
  endtask

  task automatic drive_line(input logic level, input int count);
    rxd = level;
    wait_cycles(count);
  endtask

  task automatic send_frame(input rx_byte_t data, input logic parity_bit, input logic stop_bit);
    drive_line(1'b0, BIT_CYCLES); // start bit
    for (int i = 0; i < `RX_DATA_BITS; i++)
    begin
      drive_line(data[i], BIT_CYCLES); // LSB first
    end
    drive_line(parity_bit, BIT_CYCLES);
    drive_line(stop_bit, BIT_CYCLES);
  endtask

  task automatic check_quiet_outputs();
    if (rx_valid !== 1'b0 || rx_perror !== 1'b0 || rx_ferror !== 1'b0)
    begin
      $display("an output pulse is high right after reset");
      error_count++;
    end
    if (rx_data !== '0)
    begin
      $display("error rx_data got %h expected %h", rx_data, 8'h00);
      error_count++;
    end
  endtask

  // compare one result pulse with the oldest expected frame
  task automatic check_result();
    rx_byte_t exp_data;
    logic     exp_perr;
    logic     exp_ferr;
    logic     exp_valid;
    int       latency;
    if (exp_data_q.size() == 0)
    begin
      $display("output pulse at cycle %0d with no frame outstanding", cycle_count);
      error_count++;
    end
    else
    begin
      exp_data  = exp_data_q.pop_front();
      exp_perr  = exp_perr_q.pop_front();
      exp_ferr  = exp_ferr_q.pop_front();
      latency   = cycle_count - exp_start_q.pop_front();
      exp_valid = !exp_perr && !exp_ferr;
      if (exp_valid)
      begin
        model_data = exp_data; // only a clean frame updates rx_data
      end
      if (rx_valid !== exp_valid)
      begin
        $display("error rx_valid got %h expected %h", rx_valid, exp_valid);
        error_count++;
      end
      if (rx_perror !== exp_perr)
      begin
        $display("error rx_perror got %h expected %h", rx_perror, exp_perr);
        error_count++;
      end
      if (rx_ferror !== exp_ferr)
      begin
        $display("error rx_ferror got %h expected %h", rx_ferror, exp_ferr);
        error_count++;
      end
      if (rx_data !== model_data)
      begin
        $display("error rx_data got %h expected %h", rx_data, model_data);
        error_count++;
      end
      if (latency < LAT_MIN || latency > LAT_MAX)
      begin
        $display("result came %0d cycles after its start edge, outside the window", latency);
        error_count++;
      end
      results_seen++;
    end
  endtask

  // outputs are registered on the rising edge, stable here
  always @(negedge Rx_sample_ENABLE)
  begin
    if (monitor_on)
    begin
      pulse_now = rx_valid | rx_perror | rx_ferror;
      if (pulse_now && pulse_prev)
      begin
        $display("output pulse at cycle %0d lasted more than one cycle", cycle_count);
        error_count++;
      end
      else if (pulse_now)
      begin
        check_result();
      end
      pulse_prev = pulse_now;
    end
  end

  initial
  begin
    rx_byte_t data;
    logic     flip_parity;
    logic     bad_stop;
    logic     glitch;
    logic     enabled;
    logic     prev_bad_stop;
    int       gap;
    Rx_sample_ENABLE = 1'b0;
    reset            = 1'b1;
    rx_en            = 1'b0;
    rxd              = 1'b1; // line idles high
    rng              = 32'hb0b6;
    prev_bad_stop    = 1'b0;
    wait_cycles(3); // reset over three rising edges
    reset = 1'b0;
    wait_cycles(1);
    check_quiet_outputs();
    monitor_on = 1'b1;
    for (int frame = 0; frame < NUM_FRAMES; frame++)
    begin
      rng         = xorshift32(rng);
      data        = rng[7:0];
      flip_parity = (rng[10:8] == 3'd0);   // about one in eight
      bad_stop    = (rng[13:11] == 3'd0);
      gap         = (rng[15:14] == 2'd0) ? 0 : int'(rng[23:16]) % (GAP_MAX + 1);
      glitch      = (rng[27:24] == 4'd0);  // rare false start
      enabled     = (rng[30:28] != 3'd0);
      if (prev_bad_stop && gap < 4)
      begin
        gap = 4; // a low stop bit needs the line to rise before the next start edge
      end
      rx_en = enabled; // changes only between frames
      drive_line(1'b1, gap);
      if (glitch)
      begin
        drive_line(1'b0, GLITCH_LOW);
        drive_line(1'b1, GLITCH_SETTLE);
      end
      if (enabled)
      begin
        exp_data_q.push_back(data);
        exp_perr_q.push_back(flip_parity);
        exp_ferr_q.push_back(bad_stop);
        exp_start_q.push_back(cycle_count);
      end
      send_frame(data, (^data) ^ flip_parity, ~bad_stop); // even parity unless flipped
      prev_bad_stop = bad_stop;
      frames_sent++;
    end
    rxd = 1'b1;
    while (exp_data_q.size() != 0)
    begin
      wait_cycles(1);
    end
    wait_cycles(2 * BIT_CYCLES); // room for any stray pulse
    $display("frames sent %0d, results checked %0d, errors %0d",
             frames_sent, results_seen, error_count);
    if (error_count == 0)
    begin
      $display("Simulation passed");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

  // limit from the longest possible frame slot times the frame count
  initial
  begin
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge Rx_sample_ENABLE);
    end
    $display("run did not finish within %0d cycles, %0d results still outstanding",
             TIMEOUT_CYCLES, exp_data_q.size());
    $display("frames sent %0d, results checked %0d, errors %0d",
             frames_sent, results_seen, error_count);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+source
source/uart_rx_pkg.sv
source/rx_line_frontend.sv
source/rx_bit_timer.sv
source/rx_data_shifter.sv
source/rx_frame_checker.sv
source/rx_control.sv
source/uart_rx_top.sv
verification/uart_rx_tb.sv
